/* hw/accel_core_config.svh */
`ifndef ACCEL_CORE_CONFIG_SVH
`define ACCEL_CORE_CONFIG_SVH

// neurons per vector, also weights per row
`define ACCEL_VEC_LEN 8

`define ACCEL_SLOT_NUM 3

`define ACCEL_DATA_W 8
`define ACCEL_ACC_W 20
`define ACCEL_ACC_SHIFT 4

// neuron index and row count, row count never above VEC_LEN
`define ACCEL_IDX_W 4

`endif

/* hw/accel_core_pkg.sv */
`include "accel_core_config.svh"

package accel_core_pkg;

    typedef logic signed [`ACCEL_DATA_W-1:0] t_elem;
    typedef t_elem [`ACCEL_VEC_LEN-1:0] t_vec;

    typedef struct packed {
        logic [`ACCEL_IDX_W-1:0] row_count;
    } t_layer_meta;

    // input and output vectors
    typedef struct packed {
        t_vec        data;
        t_layer_meta meta_data;
    } t_buffer_inout;

    typedef struct packed {
        logic [`ACCEL_IDX_W-1:0] neuron_idx;
    } t_weight_meta;

    // one weight row, tagged with the neuron it computes
    typedef struct packed {
        t_vec         data;
        t_weight_meta meta_data;
    } t_buffer_weights;

    typedef enum logic [1:0] {W1 = 2'd0, W2 = 2'd1, W3 = 2'd2, NONE = 2'd3} t_buffer_sel;

    typedef enum logic [1:0] {IDLE, ACCUM, FINISH} t_mac_state;

    typedef struct packed {
        logic            en;
        t_buffer_sel     sel;
        t_buffer_weights row;
    } t_slot_write;

    // lowest set bit of a slot mask, NONE when empty
    function automatic t_buffer_sel first_slot(input logic [`ACCEL_SLOT_NUM-1:0] mask);
        t_buffer_sel sel;
        sel = NONE;
        for (int i = `ACCEL_SLOT_NUM - 1; i >= 0; i--) begin
            if (mask[i]) begin
                sel = t_buffer_sel'(i);
            end
        end
        return sel;
    endfunction

endpackage

/* hw/accel_core_weight_loader.sv */
`timescale 1ns/1ps
`include "accel_core_config.svh"

module accel_core_weight_loader (
    input  logic                          Clock,
    input  logic                          rst_n,
    input  logic                          in_load,
    input  logic                          w_load,
    input  accel_core_pkg::t_vec          w_data,
    input  logic [`ACCEL_SLOT_NUM-1:0]    slot_full,
    output logic                          w_ready,
    output accel_core_pkg::t_slot_write   slot_wr
);
    import accel_core_pkg::*;

    logic [`ACCEL_IDX_W-1:0] neuron_cnt;
    logic                    accept;
    t_buffer_sel             free_sel;

    logic            wr_en_q;
    t_buffer_sel     wr_sel_q;
    t_buffer_weights wr_row_q;

    // slot_full already counts a write still in flight
    assign w_ready  = ~&slot_full;
    assign accept   = w_load & w_ready;
    assign free_sel = first_slot(~slot_full);

    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            neuron_cnt <= '0;
            wr_en_q    <= 1'b0;
        end else begin
            wr_en_q <= accept;
            if (in_load) begin
                neuron_cnt <= '0;
            end else if (accept) begin
                neuron_cnt <= neuron_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (accept) begin
            wr_sel_q                     <= free_sel;
            wr_row_q.data                <= w_data;
            wr_row_q.meta_data.neuron_idx <= neuron_cnt;
        end
    end

    always_comb begin
        slot_wr.en  = wr_en_q;
        slot_wr.sel = wr_sel_q;
        slot_wr.row = wr_row_q;
    end

endmodule

/* hw/accel_core_weight_slots.sv */
`timescale 1ns/1ps
`include "accel_core_config.svh"

module accel_core_weight_slots (
    input  logic                              Clock,
    input  logic                              rst_n,
    input  accel_core_pkg::t_slot_write       slot_wr,
    input  logic                              release_w1,
    input  logic                              release_w2,
    input  logic                              release_w3,
    output logic [`ACCEL_SLOT_NUM-1:0]        slot_full,
    output accel_core_pkg::t_buffer_weights   slot_row_1,
    output accel_core_pkg::t_buffer_weights   slot_row_2,
    output accel_core_pkg::t_buffer_weights   slot_row_3
);
    import accel_core_pkg::*;

    logic [`ACCEL_SLOT_NUM-1:0] full_q;
    logic [`ACCEL_SLOT_NUM-1:0] wr_hit;
    logic [`ACCEL_SLOT_NUM-1:0] rel;
    t_buffer_weights            row_q [`ACCEL_SLOT_NUM];

    assign rel = {release_w3, release_w2, release_w1};

    always_comb begin
        wr_hit = '0;
        if (slot_wr.en) begin
            wr_hit[slot_wr.sel] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // full flags

    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= '0;
        end else begin
            full_q <= (full_q | wr_hit) & ~rel;
        end
    end

    // a pending write shows as full right away, so the loader
    // never picks the same slot twice in a row
    assign slot_full = full_q | wr_hit;

    //////////////////////////////////////////////////////////////////////
    // row storage

    always_ff @(posedge Clock) begin
        if (slot_wr.en) begin
            row_q[slot_wr.sel] <= slot_wr.row;
        end
    end

    assign slot_row_1 = row_q[0];
    assign slot_row_2 = row_q[1];
    assign slot_row_3 = row_q[2];

endmodule

/* hw/accel_core_mac_unit.sv */
`timescale 1ns/1ps
`include "accel_core_config.svh"

module accel_core_mac_unit (
    input  logic                              Clock,
    input  logic                              rst_n,
    input  logic                              clear,
    input  logic                              start,
    input  accel_core_pkg::t_vec              neuron_in,
    input  accel_core_pkg::t_buffer_weights   w1,
    output logic signed [`ACCEL_DATA_W-1:0]   result,
    output logic                              out_valid
);
    import accel_core_pkg::*;

    localparam int LANE_W = $clog2(`ACCEL_VEC_LEN);
    localparam int ACC_W  = `ACCEL_ACC_W;
    localparam logic signed [ACC_W-1:0] SAT_MAX = 2 ** (`ACCEL_DATA_W - 1) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -(2 ** (`ACCEL_DATA_W - 1));

    t_mac_state                          state;
    logic [LANE_W-1:0]                   lane;
    logic signed [ACC_W-1:0]             acc;
    logic signed [2*`ACCEL_DATA_W-1:0]   prod;
    logic signed [ACC_W-1:0]             shifted;

    assign prod = $signed(neuron_in[lane]) * $signed(w1.data[lane]);

    // lane 0 is taken on the start edge, out_valid lands VEC_LEN cycles later
    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            lane  <= '0;
        end else if (clear) begin
            state <= IDLE;
            lane  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= ACCUM;
                        lane  <= lane + 1'b1;
                    end
                end
                ACCUM: begin
                    lane <= lane + 1'b1;
                    if (lane == LANE_W'(`ACCEL_VEC_LEN - 1)) begin
                        state <= FINISH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == IDLE) begin
            acc <= prod;
        end else if (state == ACCUM) begin
            acc <= acc + prod;
        end
    end

    assign shifted   = acc >>> `ACCEL_ACC_SHIFT;
    assign out_valid = (state == FINISH);

    always_comb begin
        if (shifted > SAT_MAX) begin
            result = SAT_MAX[`ACCEL_DATA_W-1:0];
        end else if (shifted < SAT_MIN) begin
            result = SAT_MIN[`ACCEL_DATA_W-1:0];
        end else begin
            result = shifted[`ACCEL_DATA_W-1:0];
        end
    end

endmodule

/* hw/accel_core_mul_top.sv */
`timescale 1ns/1ps
`include "accel_core_config.svh"

module accel_core_mul_top (
    input  logic                              Clock,
    input  logic                              rst_n,
    input  logic                              in_load,
    input  accel_core_pkg::t_buffer_inout     input_vec,
    input  accel_core_pkg::t_buffer_weights   w1,
    input  accel_core_pkg::t_buffer_weights   w2,
    input  accel_core_pkg::t_buffer_weights   w3,
    input  logic [`ACCEL_SLOT_NUM-1:0]        slot_full,
    output accel_core_pkg::t_buffer_inout     output_vec,
    output logic                              release_w1,
    output logic                              release_w2,
    output logic                              release_w3,
    output logic                              done_layer
);
    import accel_core_pkg::*;

    localparam int IDX_W = `ACCEL_IDX_W;

    logic                            start_m1;
    logic                            start_m2;
    logic                            out_valid_m1;
    logic                            out_valid_m2;
    t_buffer_sel                     assign_m1;
    t_buffer_sel                     assign_m2;
    t_buffer_weights                 weight_m1;
    t_buffer_weights                 weight_m2;
    logic signed [`ACCEL_DATA_W-1:0] result_m1;
    logic signed [`ACCEL_DATA_W-1:0] result_m2;

    logic [`ACCEL_SLOT_NUM-1:0] claimed;
    logic [`ACCEL_SLOT_NUM-1:0] avail;
    logic [`ACCEL_SLOT_NUM-1:0] avail_b;
    logic [`ACCEL_SLOT_NUM-1:0] release_vec;
    t_buffer_sel                pick_a;
    t_buffer_sel                pick_m2;
    logic [IDX_W-1:0]           done_cnt_next;

    function automatic t_buffer_weights slot_mux(input t_buffer_sel sel,
                                                 input t_buffer_weights a,
                                                 input t_buffer_weights b,
                                                 input t_buffer_weights c);
        case (sel)
            W1:      return a;
            W2:      return b;
            W3:      return c;
            default: return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // controller: slot to unit assignment

    always_comb begin
        for (int i = 0; i < `ACCEL_SLOT_NUM; i++) begin
            claimed[i]     = (assign_m1 == t_buffer_sel'(i)) || (assign_m2 == t_buffer_sel'(i));
            release_vec[i] = (out_valid_m1 && assign_m1 == t_buffer_sel'(i)) ||
                             (out_valid_m2 && assign_m2 == t_buffer_sel'(i));
        end
        avail   = slot_full & ~claimed;
        pick_a  = first_slot(avail);
        avail_b = avail;
        if (pick_a != NONE) begin
            avail_b[pick_a] = 1'b0;
        end
        // m1 wins when both are idle
        pick_m2 = (assign_m1 == NONE) ? first_slot(avail_b) : pick_a;
    end

    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            assign_m1 <= NONE;
            assign_m2 <= NONE;
            start_m1  <= 1'b0;
            start_m2  <= 1'b0;
        end else begin
            start_m1 <= 1'b0;
            start_m2 <= 1'b0;
            if (in_load) begin
                assign_m1 <= NONE;
                assign_m2 <= NONE;
            end else begin
                if (out_valid_m1) begin
                    assign_m1 <= NONE;
                end else if (assign_m1 == NONE && pick_a != NONE) begin
                    assign_m1 <= pick_a;
                    start_m1  <= 1'b1;
                end
                if (out_valid_m2) begin
                    assign_m2 <= NONE;
                end else if (assign_m2 == NONE && pick_m2 != NONE) begin
                    assign_m2 <= pick_m2;
                    start_m2  <= 1'b1;
                end
            end
        end
    end

    assign release_w1 = release_vec[0];
    assign release_w2 = release_vec[1];
    assign release_w3 = release_vec[2];

    assign weight_m1 = slot_mux(assign_m1, w1, w2, w3);
    assign weight_m2 = slot_mux(assign_m2, w1, w2, w3);

    accel_core_mac_unit m1 (
        .Clock     (Clock),
        .rst_n     (rst_n),
        .clear     (in_load),
        .start     (start_m1),
        .neuron_in (input_vec.data),
        .w1        (weight_m1),
        .result    (result_m1),
        .out_valid (out_valid_m1)
    );

    accel_core_mac_unit m2 (
        .Clock     (Clock),
        .rst_n     (rst_n),
        .clear     (in_load),
        .start     (start_m2),
        .neuron_in (input_vec.data),
        .w1        (weight_m2),
        .result    (result_m2),
        .out_valid (out_valid_m2)
    );

    //////////////////////////////////////////////////////////////////////
    // output vector, meta_data counts finished rows

    assign done_cnt_next = output_vec.meta_data.row_count + IDX_W'(out_valid_m1)
                         + IDX_W'(out_valid_m2);

    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            output_vec <= '0;
            done_layer <= 1'b0;
        end else begin
            done_layer <= 1'b0;
            if (in_load) begin
                output_vec <= '0;
            end else begin
                if (out_valid_m1) begin
                    output_vec.data[weight_m1.meta_data.neuron_idx] <= result_m1;
                end
                if (out_valid_m2) begin
                    output_vec.data[weight_m2.meta_data.neuron_idx] <= result_m2;
                end
                if (out_valid_m1 || out_valid_m2) begin
                    output_vec.meta_data.row_count <= done_cnt_next;
                    done_layer <= (done_cnt_next == input_vec.meta_data.row_count);
                end
            end
        end
    end

endmodule

/* hw/accel_core_top.sv */
`timescale 1ns/1ps
`include "accel_core_config.svh"

module accel_core_top (
    input  logic                            Clock,
    input  logic                            rst_n,
    input  logic                            in_load,
    input  accel_core_pkg::t_buffer_inout   in_vec,
    input  logic                            w_load,
    input  accel_core_pkg::t_vec            w_data,
    output logic                            w_ready,
    output accel_core_pkg::t_buffer_inout   out_vec,
    output logic                            done_layer
);
    import accel_core_pkg::*;

    t_buffer_inout              in_vec_q;
    t_slot_write                slot_wr;
    logic [`ACCEL_SLOT_NUM-1:0] slot_full;
    t_buffer_weights            slot_row_1;
    t_buffer_weights            slot_row_2;
    t_buffer_weights            slot_row_3;
    logic                       release_w1;
    logic                       release_w2;
    logic                       release_w3;

    // input activations, held for the whole layer
    always_ff @(posedge Clock) begin
        if (in_load) begin
            in_vec_q <= in_vec;
        end
    end

    accel_core_weight_loader u_loader (
        .Clock     (Clock),
        .rst_n     (rst_n),
        .in_load   (in_load),
        .w_load    (w_load),
        .w_data    (w_data),
        .slot_full (slot_full),
        .w_ready   (w_ready),
        .slot_wr   (slot_wr)
    );

    accel_core_weight_slots u_slots (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .slot_wr    (slot_wr),
        .release_w1 (release_w1),
        .release_w2 (release_w2),
        .release_w3 (release_w3),
        .slot_full  (slot_full),
        .slot_row_1 (slot_row_1),
        .slot_row_2 (slot_row_2),
        .slot_row_3 (slot_row_3)
    );

    accel_core_mul_top u_mul (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .in_load    (in_load),
        .input_vec  (in_vec_q),
        .w1         (slot_row_1),
        .w2         (slot_row_2),
        .w3         (slot_row_3),
        .slot_full  (slot_full),
        .output_vec (out_vec),
        .release_w1 (release_w1),
        .release_w2 (release_w2),
        .release_w3 (release_w3),
        .done_layer (done_layer)
    );

endmodule

/* sim/accel_core_asserts.sv */
`timescale 1ns/1ps
`include "accel_core_config.svh"

module accel_core_asserts (
    input logic                              Clock,
    input logic                              rst_n,
    input logic [`ACCEL_SLOT_NUM-1:0]        slot_full,
    input logic                              release_w1,
    input logic                              release_w2,
    input logic                              release_w3,
    input accel_core_pkg::t_buffer_sel       assign_m1,
    input accel_core_pkg::t_buffer_sel       assign_m2,
    input logic                              start_m1,
    input logic                              start_m2,
    input logic                              out_valid_m1,
    input logic                              out_valid_m2,
    input logic                              done_layer
);
    import accel_core_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // slot protocol

    rel_w1_full: assert property (@(posedge Clock) disable iff (!rst_n)
        release_w1 |-> slot_full[0]) else $error("release of empty slot 1");
    rel_w2_full: assert property (@(posedge Clock) disable iff (!rst_n)
        release_w2 |-> slot_full[1]) else $error("release of empty slot 2");
    rel_w3_full: assert property (@(posedge Clock) disable iff (!rst_n)
        release_w3 |-> slot_full[2]) else $error("release of empty slot 3");

    // both units on one slot would compute the same row twice
    unique_claim: assert property (@(posedge Clock) disable iff (!rst_n)
        (assign_m1 != NONE) |-> (assign_m1 != assign_m2))
        else $error("both MAC units hold the same slot");

    //////////////////////////////////////////////////////////////////////
    // MAC latency and done pulse

    m1_latency: assert property (@(posedge Clock) disable iff (!rst_n)
        start_m1 |-> ##8 out_valid_m1) else $error("m1 out_valid not 8 cycles after start");
    m2_latency: assert property (@(posedge Clock) disable iff (!rst_n)
        start_m2 |-> ##8 out_valid_m2) else $error("m2 out_valid not 8 cycles after start");

    done_single: assert property (@(posedge Clock) disable iff (!rst_n)
        done_layer |=> !done_layer) else $error("done_layer longer than one cycle");

endmodule

bind accel_core_mul_top accel_core_asserts u_asserts (
    .Clock        (Clock),
    .rst_n        (rst_n),
    .slot_full    (slot_full),
    .release_w1   (release_w1),
    .release_w2   (release_w2),
    .release_w3   (release_w3),
    .assign_m1    (assign_m1),
    .assign_m2    (assign_m2),
    .start_m1     (start_m1),
    .start_m2     (start_m2),
    .out_valid_m1 (out_valid_m1),
    .out_valid_m2 (out_valid_m2),
    .done_layer   (done_layer)
);

/* sim/accel_core_tb.sv */
`timescale 1ns/1ps
`include "accel_core_config.svh"

module accel_core_tb;
    import accel_core_pkg::*;

    localparam string STIM_FILE = "sim/accel_core_stim.txt";
    localparam int ROW_LIMIT  = 100;
    localparam int DONE_LIMIT = 200;

    logic          Clock;
    logic          rst_n;
    logic          in_load;
    t_buffer_inout in_vec;
    logic          w_load;
    t_vec          w_data;
    logic          w_ready;
    t_buffer_inout out_vec;
    logic          done_layer;

    logic [31:0] rnd_state;
    logic        gaps_on;
    logic        saw_stall;
    int          layers_run;

    accel_core_top accel_core_top_i (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .in_load    (in_load),
        .in_vec     (in_vec),
        .w_load     (w_load),
        .w_data     (w_data),
        .w_ready    (w_ready),
        .out_vec    (out_vec),
        .done_layer (done_layer)
    );

    always #5 Clock = ~Clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_sim();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_hex(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            abort_sim();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks, entered and left right after a rising edge

    task automatic start_layer(input logic [`ACCEL_IDX_W-1:0] rc, input t_vec vec);
        in_load                   <= 1'b1;
        in_vec.data               <= vec;
        in_vec.meta_data.row_count <= rc;
        @(posedge Clock);
        in_load <= 1'b0;
        // previous result must be gone one cycle after in_load
        @(negedge Clock);
        check_hex("out_vec.data", '0, out_vec.data);
        @(posedge Clock);
    endtask

    // w_load stays high until a cycle with w_ready high takes the row
    task automatic send_row(input t_vec row);
        int   waited;
        logic taken;
        waited  = 0;
        taken   = 1'b0;
        w_load <= 1'b1;
        w_data <= row;
        while (!taken) begin
            @(negedge Clock);
            taken = w_ready;
            if (!w_ready) begin
                saw_stall = 1'b1;
            end
            waited++;
            assert (waited < ROW_LIMIT) else begin
                $display("timeout, w_ready stayed low for %0d cycles", ROW_LIMIT);
                abort_sim();
            end
            @(posedge Clock);
        end
    endtask

    task automatic idle_gap();
        int n;
        rnd_state = xorshift32(rnd_state);
        n = int'(rnd_state[1:0]);
        if (n != 0) begin
            w_load <= 1'b0;
            repeat (n) @(posedge Clock);
        end
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge Clock);
        while (done_layer !== 1'b1) begin
            waited++;
            assert (waited < DONE_LIMIT) else begin
                $display("timeout, done_layer did not pulse within %0d cycles", DONE_LIMIT);
                abort_sim();
            end
            @(negedge Clock);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          rc;
        int          gap_flag;
        string       kind;
        string       rest;
        logic [63:0] hex;
        Clock      = 1'b0;
        rst_n      = 1'b0;
        in_load    = 1'b0;
        in_vec     = '0;
        w_load     = 1'b0;
        w_data     = '0;
        rnd_state  = 32'hab13;
        gaps_on    = 1'b1;
        saw_stall  = 1'b0;
        layers_run = 0;

        repeat (3) @(posedge Clock);
        rst_n <= 1'b1;
        @(negedge Clock);
        check_hex("w_ready", 64'h1, 64'(w_ready));
        check_hex("done_layer", 64'h0, 64'(done_layer));
        check_hex("out_vec.data", '0, out_vec.data);

        fd = $fopen(STIM_FILE, "r");
        assert (fd != 0) else begin
            $display("could not open the stimulus file %s", STIM_FILE);
            abort_sim();
        end
        @(posedge Clock);

        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                continue;
            end
            if (kind.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "L") begin
                code = $fscanf(fd, "%d %d %h", rc, gap_flag, hex);
                assert (code == 3) else begin
                    $display("malformed layer record in the stimulus file");
                    abort_sim();
                end
                gaps_on   = (gap_flag != 0);
                saw_stall = 1'b0;
                start_layer(rc[`ACCEL_IDX_W-1:0], hex);
            end else if (kind == "W") begin
                code = $fscanf(fd, "%h", hex);
                assert (code == 1) else begin
                    $display("malformed weight record in the stimulus file");
                    abort_sim();
                end
                send_row(hex);
                if (gaps_on) begin
                    idle_gap();
                end
            end else if (kind == "E") begin
                code = $fscanf(fd, "%h", hex);
                assert (code == 1) else begin
                    $display("malformed expected-output record in the stimulus file");
                    abort_sim();
                end
                w_load <= 1'b0;
                wait_done();
                check_hex("out_vec.data", hex, out_vec.data);
                // completed rows counted up to the layer's row_count
                check_hex("out_vec.meta_data.row_count", 64'(rc),
                          64'(out_vec.meta_data.row_count));
                // back to back loads must have filled all three slots
                assert (gaps_on || saw_stall) else begin
                    $display("w_ready never dropped during back to back weight loads");
                    abort_sim();
                end
                layers_run++;
                @(posedge Clock);
            end else begin
                $display("unknown record kind %s in the stimulus file", kind);
                abort_sim();
            end
        end
        $fclose(fd);

        assert (layers_run > 0) else begin
            $display("the stimulus file held no complete layer");
            abort_sim();
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* accel_core.f */
+incdir+hw
hw/accel_core_pkg.sv
hw/accel_core_weight_loader.sv
hw/accel_core_weight_slots.sv
hw/accel_core_mac_unit.sv
hw/accel_core_mul_top.sv
hw/accel_core_top.sv
sim/accel_core_asserts.sv
sim/accel_core_tb.sv

/* Bender.yml */
package:
  name: accel_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/accel_core_pkg.sv
      - hw/accel_core_weight_loader.sv
      - hw/accel_core_weight_slots.sv
      - hw/accel_core_mac_unit.sv
      - hw/accel_core_mul_top.sv
      - hw/accel_core_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/accel_core_asserts.sv
      - sim/accel_core_tb.sv

/* sim/accel_core_stim.txt */
# L row_count gaps(1 random idle cycles, 0 back to back) in_vec | W weight_row | E out_vec
# vectors are hex, element 7 leftmost and element 0 rightmost
L 8 1 0807060504030201
W 1010101010101010
W 0807060504030201
W ffffffffffffffff
W 4000000000000000
W 0000000000000080
W f808f808f808f808
W 2020202020202020
W 0303030303030303
E 0648fef820fd0c24
L 8 0 7f7f7f7f7f7f7f7f
W 7f7f7f7f7f7f7f7f
W 8080808080808080
W 0101010101010101
W ffffffffffffffff
W 000000000000007f
W 0202020202020202
W fefefefefefefefe
W fdfdfdfdfdfdfdfd
E 80817f7fc03f807f
L 3 1 1010101010101010
W 0101010101010101
W fefefefefefefefe
W 0000000000000005
E 000000000005f008
